// ==== hw/conv_pkg.sv ====
package conv_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Data widths and image geometry

	// Pixel word width
	localparam int DATA_WIDTH = 16;

	// Pixels per row and rows per frame
	localparam int IMAGE_WIDTH  = 8;
	localparam int IMAGE_HEIGHT = 8;

	// Row and column counter width
	localparam int POS_WIDTH = 3;

	////////////////////////////////////////////////////////////////////////////
	// Stream types

	typedef logic signed [DATA_WIDTH-1:0] data_t;

	// Largest positive pixel value, its complement is the most negative one
	localparam data_t DATA_MAX = data_t'({1'b0, {(DATA_WIDTH-1){1'b1}}});

	// One beat of the pixel stream
	typedef struct packed {
		logic  valid;
		data_t data;
	} pxl_beat_t;

	// Output selection, held stable within a frame
	typedef enum logic [1:0] {
		MODE_PASS    = 2'd0,
		MODE_STRIDE2 = 2'd1,
		MODE_POOL    = 2'd2
	} out_mode_t;

endpackage

// ==== hw/d_flip_flop.sv ====
`timescale 1ns/10ps

module d_flip_flop (
	input  logic                clk,
	input  logic                reset,
	input  conv_pkg::pxl_beat_t beat_in,
	output conv_pkg::pxl_beat_t beat_out
);

	// Valid follows every cycle, data holds the last valid pixel through gaps
	always_ff @(posedge clk) begin
		if (reset) begin
			beat_out <= '0;
		end else begin
			beat_out.valid <= beat_in.valid;
			if (beat_in.valid) begin
				beat_out.data <= beat_in.data;
			end
		end
	end

endmodule

// ==== hw/line_buffer.sv ====
`timescale 1ns/10ps

module line_buffer #(
	parameter int DEPTH = conv_pkg::IMAGE_WIDTH
) (
	input  logic                clk,
	input  logic                reset,
	input  conv_pkg::pxl_beat_t beat_in,
	output conv_pkg::data_t     data_out
);

	import conv_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Shift line, one word per valid beat

	data_t shift_line [DEPTH];

	// Slot 0 takes the new pixel, the rest move up by one
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++) begin
				shift_line[i] <= '0;
			end
		end else if (beat_in.valid) begin
			shift_line[0] <= beat_in.data;
			for (int i = 1; i < DEPTH; i++) begin
				shift_line[i] <= shift_line[i-1];
			end
		end
	end

	// Word that entered DEPTH valid beats ago,
	// i.e. same column of the previous row when DEPTH is the row length
	assign data_out = shift_line[DEPTH-1];

endmodule

// ==== hw/bias_relu.sv ====
`timescale 1ns/10ps

module bias_relu (
	input  logic                clk,
	input  logic                reset,
	input  conv_pkg::data_t     bias,
	input  conv_pkg::pxl_beat_t beat_in,
	output conv_pkg::pxl_beat_t beat_out
);

	import conv_pkg::*;

	// One extra bit to see the overflow
	logic signed [DATA_WIDTH:0] sum;
	data_t                      sat_data;
	data_t                      relu_data;

	////////////////////////////////////////////////////////////////////////////
	// Saturating add then ReLU

	always_comb begin
		sum = {beat_in.data[DATA_WIDTH-1], beat_in.data} + {bias[DATA_WIDTH-1], bias};

		// Top two bits differ on overflow, the top bit gives the direction
		if (sum[DATA_WIDTH] != sum[DATA_WIDTH-1]) begin
			sat_data = sum[DATA_WIDTH] ? ~DATA_MAX : DATA_MAX;
		end else begin
			sat_data = sum[DATA_WIDTH-1:0];
		end

		// Negative results go to zero
		relu_data = sat_data[DATA_WIDTH-1] ? '0 : sat_data;
	end

	// Output stage
	always_ff @(posedge clk) begin
		if (reset) begin
			beat_out.valid <= 1'b0;
		end else begin
			beat_out.valid <= beat_in.valid;
		end
	end

	always_ff @(posedge clk) begin
		beat_out.data <= relu_data;
	end

endmodule

// ==== hw/max_pool_2x2.sv ====
`timescale 1ns/10ps

module max_pool_2x2 (
	input  logic                clk,
	input  logic                reset,
	input  conv_pkg::pxl_beat_t beat_in,
	output conv_pkg::pxl_beat_t beat_out
);

	import conv_pkg::*;

	data_t     above_data;
	pxl_beat_t above_beat;
	pxl_beat_t left_beat;
	pxl_beat_t above_left_beat;
	data_t     window_max;

	function automatic data_t max2(input data_t a, input data_t b);
		return (a > b) ? a : b;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Neighbour pixels of the current beat

	// Pixel one row up
	line_buffer #(
		.DEPTH(IMAGE_WIDTH)
	) line_buffer0 (
		.clk     (clk),
		.reset   (reset),
		.beat_in (beat_in),
		.data_out(above_data)
	);

	// Pixel to the left is the last valid input
	d_flip_flop left_dff (
		.clk     (clk),
		.reset   (reset),
		.beat_in (beat_in),
		.beat_out(left_beat)
	);

	// Above-left is the above pixel of the previous valid beat
	assign above_beat = '{valid: beat_in.valid, data: above_data};

	d_flip_flop above_left_dff (
		.clk     (clk),
		.reset   (reset),
		.beat_in (above_beat),
		.beat_out(above_left_beat)
	);

	////////////////////////////////////////////////////////////////////////////
	// Window maximum

	// No notion of position here, straddling windows are dropped downstream
	assign window_max = max2(max2(beat_in.data, left_beat.data),
		max2(above_data, above_left_beat.data));

	always_ff @(posedge clk) begin
		if (reset) begin
			beat_out <= '0;
		end else begin
			beat_out.valid <= beat_in.valid;
			if (beat_in.valid) begin
				beat_out.data <= window_max;
			end
		end
	end

endmodule

// ==== hw/conv_align_stride2_pooling_output.sv ====
`timescale 1ns/10ps

module conv_align_stride2_pooling_output (
	input  logic                clk,
	input  logic                reset,
	input  conv_pkg::out_mode_t mode,
	input  conv_pkg::pxl_beat_t beat_in,
	output conv_pkg::pxl_beat_t pxl_out
);

	import conv_pkg::*;

	logic [POS_WIDTH-1:0] col;
	logic [POS_WIDTH-1:0] row;
	logic                 keep_stride_d;
	logic                 keep_pool_d;
	pxl_beat_t            raw_d;
	pxl_beat_t            pool_d;

	////////////////////////////////////////////////////////////////////////////
	// Position of the current input beat

	always_ff @(posedge clk) begin
		if (reset) begin
			col <= '0;
			row <= '0;
		end else if (beat_in.valid) begin
			if (col == POS_WIDTH'(IMAGE_WIDTH - 1)) begin
				col <= '0;
				// End of row, wrap rows at frame end
				if (row == POS_WIDTH'(IMAGE_HEIGHT - 1)) begin
					row <= '0;
				end else begin
					row <= row + 1'b1;
				end
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	// Flags delayed to line up with raw_d and pool_d
	always_ff @(posedge clk) begin
		if (reset) begin
			keep_stride_d <= 1'b0;
			keep_pool_d   <= 1'b0;
		end else begin
			keep_stride_d <= ~row[0] & ~col[0];
			keep_pool_d   <= row[0] & col[0];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Two paths with one cycle each

	max_pool_2x2 max_pool0 (
		.clk     (clk),
		.reset   (reset),
		.beat_in (beat_in),
		.beat_out(pool_d)
	);

	// Raw beat delayed by the pool latency
	d_flip_flop raw_dff (
		.clk     (clk),
		.reset   (reset),
		.beat_in (beat_in),
		.beat_out(raw_d)
	);

	// Mode select and output register
	always_ff @(posedge clk) begin
		if (reset) begin
			pxl_out <= '0;
		end else begin
			case (mode)
				MODE_PASS: begin
					pxl_out <= raw_d;
				end
				MODE_STRIDE2: begin
					pxl_out.valid <= raw_d.valid & keep_stride_d;
					pxl_out.data  <= raw_d.data;
				end
				MODE_POOL: begin
					pxl_out.valid <= pool_d.valid & keep_pool_d;
					pxl_out.data  <= pool_d.data;
				end
				default: begin
					pxl_out.valid <= 1'b0;
				end
			endcase
		end
	end

endmodule

// ==== hw/conv_output_top.sv ====
`timescale 1ns/10ps

module conv_output_top (
	input  logic                clk,
	input  logic                reset,
	input  conv_pkg::data_t     bias,
	input  conv_pkg::out_mode_t mode,
	input  conv_pkg::pxl_beat_t pxl_in,
	output conv_pkg::pxl_beat_t pxl_out
);

	import conv_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Bias, ReLU, then output selection

	// Stream between the two stages
	pxl_beat_t relu_beat;

	bias_relu bias_relu0 (
		.clk     (clk),
		.reset   (reset),
		.bias    (bias),
		.beat_in (pxl_in),
		.beat_out(relu_beat)
	);

	// Three cycles from pxl_in to pxl_out in every mode
	conv_align_stride2_pooling_output align0 (
		.clk    (clk),
		.reset  (reset),
		.mode   (mode),
		.beat_in(relu_beat),
		.pxl_out(pxl_out)
	);

endmodule

// ==== testbench/conv_output_tb.sv ====
`timescale 1ns/10ps

module conv_output_tb;

	import conv_pkg::*;

	localparam int PIXEL_MAX   = (1 << (DATA_WIDTH - 1)) - 1;
	localparam int LATENCY     = 3;
	localparam int DRAIN_LIMIT = 1000;

	logic      clk;
	logic      reset;
	data_t     bias;
	out_mode_t mode;
	pxl_beat_t pxl_in;
	pxl_beat_t pxl_out;

	integer seed = 32'hc79e;
	int     cycle = 0;
	int     out_count = 0;

	// Expected output pixels and the cycle each one must show up in
	data_t exp_data[$];
	int    exp_cycle[$];

	conv_output_top dut0 (
		.clk    (clk),
		.reset  (reset),
		.bias   (bias),
		.mode   (mode),
		.pxl_in (pxl_in),
		.pxl_out(pxl_out)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers

	task automatic check(input int actual, input int expected, input string what);
		if (actual != expected) begin
			$display("ERROR at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	function automatic int rand_below(input int limit);
		return $unsigned($random(seed)) % $unsigned(limit);
	endfunction

	function automatic data_t larger(input data_t a, input data_t b);
		return (a > b) ? a : b;
	endfunction

	// Bias add saturated at the top, ReLU clamps everything below zero
	function automatic data_t expected_pixel(input data_t pixel, input data_t b);
		int total;
		total = int'(pixel) + int'(b);
		if (total > PIXEL_MAX) begin
			total = PIXEL_MAX;
		end
		if (total < 0) begin
			total = 0;
		end
		return data_t'(total);
	endfunction

	// Called on the edge that drives the input, where cycle still reads one behind
	task automatic expect_beat(input data_t value);
		exp_data.push_back(value);
		exp_cycle.push_back(cycle + 1 + LATENCY);
	endtask

	// Output monitor sampled on the falling edge
	always @(negedge clk) begin
		if (pxl_out.valid) begin
			if (exp_data.size() == 0) begin
				check(1, 0, "valid output while none expected");
			end else begin
				check(int'(pxl_out.data), int'(exp_data.pop_front()), "output pixel");
				check(cycle, exp_cycle.pop_front(), "output cycle");
				out_count++;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus

	// Drives the first beats of a frame and queues what the mode keeps
	task automatic drive_frame(input out_mode_t frame_mode, input data_t frame_bias,
		input bit extremes, input int gap_pct, input int beats);
		data_t raw [IMAGE_HEIGHT][IMAGE_WIDTH];
		data_t proc [IMAGE_HEIGHT][IMAGE_WIDTH];
		data_t block_max;
		int    r;
		int    c;
		int    n;
		int    offset;

		for (r = 0; r < IMAGE_HEIGHT; r++) begin
			for (c = 0; c < IMAGE_WIDTH; c++) begin
				if (extremes) begin
					offset = rand_below(256);
					if (rand_below(2) == 1) begin
						raw[r][c] = data_t'(PIXEL_MAX - offset);
					end else begin
						raw[r][c] = data_t'(-PIXEL_MAX - 1 + offset);
					end
				end else begin
					raw[r][c] = data_t'($random(seed));
				end
				proc[r][c] = expected_pixel(raw[r][c], frame_bias);
			end
		end

		for (n = 0; n < beats; n++) begin
			r = n / IMAGE_WIDTH;
			c = n % IMAGE_WIDTH;
			if (rand_below(100) < gap_pct) begin
				repeat (rand_below(3) + 1) begin
					@(posedge clk);
					pxl_in.valid <= 1'b0;
				end
			end
			@(posedge clk);
			mode   <= frame_mode;
			bias   <= frame_bias;
			pxl_in <= '{valid: 1'b1, data: raw[r][c]};
			case (frame_mode)
				MODE_STRIDE2: begin
					if (r % 2 == 0 && c % 2 == 0) begin
						expect_beat(proc[r][c]);
					end
				end
				MODE_POOL: begin
					// Block closes at its bottom right pixel
					if (r % 2 == 1 && c % 2 == 1) begin
						block_max = larger(larger(proc[r][c], proc[r][c-1]),
							larger(proc[r-1][c], proc[r-1][c-1]));
						expect_beat(block_max);
					end
				end
				default: begin
					expect_beat(proc[r][c]);
				end
			endcase
		end

		// Let the last beats leave before the mode may change
		repeat (LATENCY) begin
			@(posedge clk);
			pxl_in.valid <= 1'b0;
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_data.size() != 0 && waited < DRAIN_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (exp_data.size() != 0) begin
			$display("Timed out with %0d expected output beats still missing", exp_data.size());
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	task automatic apply_reset(input int cycles);
		@(posedge clk);
		reset        <= 1'b1;
		pxl_in.valid <= 1'b0;
		repeat (cycles) @(posedge clk);
		reset <= 1'b0;
	endtask

	// Pass-mode beats cut off by reset, the last two are still in the pipeline
	task automatic drive_into_reset(input data_t beat_bias, input int beats);
		data_t pixel;
		int    n;

		for (n = 0; n < beats; n++) begin
			pixel = data_t'($random(seed));
			@(posedge clk);
			mode   <= MODE_PASS;
			bias   <= beat_bias;
			pxl_in <= '{valid: 1'b1, data: pixel};
			if (n < beats - 2) begin
				expect_beat(expected_pixel(pixel, beat_bias));
			end
		end
		apply_reset(5);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests

	task automatic test_pass();
		int start;
		start = out_count;
		drive_frame(MODE_PASS, data_t'(250), 1'b0, 30, 64);
		drive_frame(MODE_PASS, data_t'(-120), 1'b0, 0, 64);
		wait_drain();
		check(out_count - start, 128, "pass mode output count");
	endtask

	task automatic test_saturation();
		int start;
		start = out_count;
		drive_frame(MODE_PASS, data_t'(16384), 1'b1, 0, 64);
		drive_frame(MODE_PASS, data_t'(-16384), 1'b1, 20, 64);
		wait_drain();
		check(out_count - start, 128, "saturation output count");
	endtask

	task automatic test_stride2();
		int start;
		start = out_count;
		drive_frame(MODE_STRIDE2, data_t'(37), 1'b0, 30, 64);
		wait_drain();
		check(out_count - start, 16, "stride-2 output count");
	endtask

	task automatic test_pool();
		int start;
		start = out_count;
		drive_frame(MODE_POOL, data_t'(-500), 1'b0, 30, 64);
		wait_drain();
		check(out_count - start, 16, "pool output count");
	endtask

	task automatic test_frames_and_reset();
		int start;
		start = out_count;
		drive_frame(MODE_PASS, data_t'(0), 1'b0, 10, 64);
		drive_frame(MODE_STRIDE2, data_t'(900), 1'b0, 10, 64);
		drive_frame(MODE_POOL, data_t'(-60), 1'b0, 10, 64);
		wait_drain();
		check(out_count - start, 96, "back-to-back output count");

		// Frame abandoned partway with beats in flight, none may leave after reset
		start = out_count;
		drive_into_reset(data_t'(15), 29);
		repeat (LATENCY) @(posedge clk);
		check(out_count - start, 27, "output count around reset");

		start = out_count;
		drive_frame(MODE_POOL, data_t'(75), 1'b0, 25, 64);
		wait_drain();
		check(out_count - start, 16, "pool after reset output count");
	endtask

	initial begin
		reset  = 1'b1;
		bias   = '0;
		mode   = MODE_PASS;
		pxl_in = '0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		test_pass();
		test_saturation();
		test_stride2();
		test_pool();
		test_frames_and_reset();

		$display("All tests passed");
		$finish;
	end

endmodule

// ==== all.f ====
hw/conv_pkg.sv
hw/d_flip_flop.sv
hw/line_buffer.sv
hw/bias_relu.sv
hw/max_pool_2x2.sv
hw/conv_align_stride2_pooling_output.sv
hw/conv_output_top.sv
testbench/conv_output_tb.sv

// ==== Makefile ====
.PHONY: compile run clean

compile:
	verilator --binary --timing --timescale 1ns/10ps -f all.f --top-module conv_output_tb -Mdir obj_dir -o sim

# Passes only when the simulation output holds the pass message
run: compile
	./obj_dir/sim | tee /dev/stderr | grep -q "All tests passed"

clean:
	rm -rf obj_dir
